// ==== lsu_pkg.sv ====
package lsu_pkg;

	// Integer data path width of the core
	localparam int data_w = 64;

	// Rename bits appended to the architectural register number
	localparam int rb = 2;

	// Destination tag is register number plus rename bits
	localparam int rd_w = 5 + rb;

	// Access sizes as encoded by the decoder
	typedef enum logic [1:0] {
		size_byte   = 2'd0,
		size_half   = 2'd1,
		size_word   = 2'd2,
		size_double = 2'd3
	} access_size_e;

	// Byte count of one access
	function automatic logic [3:0] size_bytes(access_size_e size);
		logic [3:0] count;
		// Encoding is log2 of the byte count
		count = 4'd1 << size;
		return count;
	endfunction

endpackage

// ==== dtcm_bank_if.sv ====
`timescale 1ns/10ps

interface dtcm_bank_if #(
	parameter int AW = 14
);

	// Doubleword row inside one bank
	logic [AW-1:0] addr;
	logic [lsu_pkg::data_w-1:0] wdata;
	logic wen;
	// One enable per byte lane
	logic [7:0] wmask;
	// Registered read word
	logic [lsu_pkg::data_w-1:0] rdata;

	// Load/store unit side
	modport unit (
		output addr,
		output wdata,
		output wen,
		output wmask,
		input  rdata
	);

	// Memory bank side
	modport mem (
		input  addr,
		input  wdata,
		input  wen,
		input  wmask,
		output rdata
	);

endinterface

// ==== dtcm.sv ====
`timescale 1ns/10ps

module dtcm #(
	parameter int AW = 14
) (
	input logic CLK,
	input logic reset,
	dtcm_bank_if.mem bank
);

	// One doubleword per row
	logic [lsu_pkg::data_w-1:0] mem [0:2**AW-1];

	// Byte lane writes
	always_ff @(posedge CLK) begin
		for (int i = 0; i < 8; i++) begin
			// Lane written only where its mask bit is set
			if (bank.wen && bank.wmask[i]) begin
				mem[bank.addr][8*i +: 8] <= bank.wdata[8*i +: 8];
			end
		end
	end

	// Read port with one cycle latency
	always_ff @(posedge CLK) begin
		if (reset) begin
			bank.rdata <= '0;
		end else begin
			// Old contents on a same-edge write
			bank.rdata <= mem[bank.addr];
		end
	end

endmodule

// ==== store_align.sv ====
`timescale 1ns/10ps

module store_align (
	input  lsu_pkg::access_size_e size,
	input  logic [63:0] addr,
	input  logic [lsu_pkg::data_w-1:0] data,
	output logic [7:0] mask_a,
	output logic [7:0] mask_b,
	output logic [lsu_pkg::data_w-1:0] data_a,
	output logic [lsu_pkg::data_w-1:0] data_b
);

	// Byte mask of the access before shifting
	logic [15:0] base_mask;
	// Mask over two doublewords in address order
	logic [15:0] mask;
	// Store data over two doublewords in address order
	logic [127:0] window;

	// Contiguous run of ones, one per byte
	assign base_mask = ~(16'hffff << lsu_pkg::size_bytes(size));

	// Move to the byte offset inside the first doubleword
	assign mask = base_mask << addr[2:0];
	assign window = {64'b0, data} << {addr[2:0], 3'b000};

	// Even first doubleword keeps order
	// Odd first doubleword belongs to bank B, so the halves swap
	always_comb begin
		if (addr[3]) begin
			mask_b = mask[7:0];
			mask_a = mask[15:8];
			data_b = window[63:0];
			data_a = window[127:64];
		end else begin
			mask_a = mask[7:0];
			mask_b = mask[15:8];
			data_a = window[63:0];
			data_b = window[127:64];
		end
	end

endmodule

// ==== load_align.sv ====
`timescale 1ns/10ps

module load_align (
	input  logic CLK,
	input  logic reset,
	input  logic accept,
	input  logic kill,
	input  lsu_pkg::access_size_e size,
	input  logic is_unsigned,
	input  logic [3:0] offset,
	input  logic [lsu_pkg::rd_w-1:0] rd,
	input  logic [lsu_pkg::data_w-1:0] rdata_a,
	input  logic [lsu_pkg::data_w-1:0] rdata_b,
	output logic wb_valid,
	output logic [lsu_pkg::data_w-1:0] wb_data,
	output logic [lsu_pkg::rd_w-1:0] wb_rd
);

	// Stage one request fields
	logic s1_valid;
	lsu_pkg::access_size_e s1_size;
	logic s1_unsigned;
	logic [3:0] s1_offset;
	logic [lsu_pkg::rd_w-1:0] s1_rd;

	// Two bank words in address order
	logic [127:0] window;
	// Access moved down to bit zero
	logic [lsu_pkg::data_w-1:0] lane;
	// Extended result
	logic [lsu_pkg::data_w-1:0] result;

	// Stage one valid dropped by a flush at the accept edge
	always_ff @(posedge CLK) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= accept & ~kill;
		end
	end

	// Request payload travels alongside the bank read
	always_ff @(posedge CLK) begin
		s1_size <= size;
		s1_unsigned <= is_unsigned;
		s1_offset <= offset;
		s1_rd <= rd;
	end

	// Odd start means bank B holds the lower doubleword
	assign window = s1_offset[3] ? {rdata_a, rdata_b} : {rdata_b, rdata_a};
	assign lane = lsu_pkg::data_w'(window >> {s1_offset[2:0], 3'b000});

	// Sign or zero extension by size
	always_comb begin
		case (s1_size)
			lsu_pkg::size_byte:
				result = s1_unsigned ? {56'b0, lane[7:0]} : {{56{lane[7]}}, lane[7:0]};
			lsu_pkg::size_half:
				result = s1_unsigned ? {48'b0, lane[15:0]} : {{48{lane[15]}}, lane[15:0]};
			lsu_pkg::size_word:
				result = s1_unsigned ? {32'b0, lane[31:0]} : {{32{lane[31]}}, lane[31:0]};
			default:
				result = lane;
		endcase
	end

	// Writeback strobe also cancelled by a flush one edge later
	always_ff @(posedge CLK) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= s1_valid & ~kill;
		end
	end

	// Result and tag
	always_ff @(posedge CLK) begin
		wb_data <= result;
		wb_rd <= s1_rd;
	end

endmodule

// ==== lsu.sv ====
`timescale 1ns/10ps

module lsu #(
	parameter int AW = 14
) (
	input  logic CLK,
	input  logic reset,
	// Load request
	input  logic lu_valid,
	output logic lu_ready,
	input  lsu_pkg::access_size_e lu_size,
	input  logic lu_unsigned,
	input  logic [63:0] lu_addr,
	input  logic [lsu_pkg::rd_w-1:0] lu_rd,
	// Store request
	input  logic su_valid,
	output logic su_ready,
	input  lsu_pkg::access_size_e su_size,
	input  logic [63:0] su_addr,
	input  logic [lsu_pkg::data_w-1:0] su_data,
	// Pipeline flush
	input  logic flush,
	// Load writeback
	output logic wb_valid,
	output logic [lsu_pkg::data_w-1:0] wb_data,
	output logic [lsu_pkg::rd_w-1:0] wb_rd,
	// Memory banks
	dtcm_bank_if.unit bank_a,
	dtcm_bank_if.unit bank_b
);

	logic load_go;
	logic store_go;
	// Address of the access that owns the banks this cycle
	logic [63:0] req_addr;
	// Row of the bank pair holding the first doubleword
	logic [AW-1:0] row;
	logic [7:0] mask_a;
	logic [7:0] mask_b;
	logic [lsu_pkg::data_w-1:0] data_a;
	logic [lsu_pkg::data_w-1:0] data_b;

	// Banks answer every cycle so loads never stall
	assign lu_ready = 1'b1;
	// Loads first
	assign su_ready = ~lu_valid;

	assign load_go = lu_valid & lu_ready;
	assign store_go = su_valid & su_ready;

	// At most one of the two owns the banks
	assign req_addr = load_go ? lu_addr : su_addr;
	assign row = req_addr[4 +: AW];

	// Odd start moves bank A one row on with wrap at the top
	assign bank_a.addr = req_addr[3] ? row + AW'(1) : row;
	// Bank B always shares the starting row
	assign bank_b.addr = row;

	// Store byte lanes per bank
	store_align store_align_inst (
		.size   (su_size),
		.addr   (su_addr),
		.data   (su_data),
		.mask_a (mask_a),
		.mask_b (mask_b),
		.data_a (data_a),
		.data_b (data_b)
	);

	// Both banks written in the accept cycle
	assign bank_a.wen = store_go;
	assign bank_a.wmask = mask_a;
	assign bank_a.wdata = data_a;
	assign bank_b.wen = store_go;
	assign bank_b.wmask = mask_b;
	assign bank_b.wdata = data_b;

	// Two stage return path
	load_align load_align_inst (
		.CLK         (CLK),
		.reset       (reset),
		.accept      (load_go),
		.kill        (flush),
		.size        (lu_size),
		.is_unsigned (lu_unsigned),
		.offset      (lu_addr[3:0]),
		.rd          (lu_rd),
		.rdata_a     (bank_a.rdata),
		.rdata_b     (bank_b.rdata),
		.wb_valid    (wb_valid),
		.wb_data     (wb_data),
		.wb_rd       (wb_rd)
	);

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top #(
	parameter int AW = 14
) (
	input  logic CLK,
	input  logic reset,
	// Load request
	input  logic lu_valid,
	output logic lu_ready,
	input  lsu_pkg::access_size_e lu_size,
	input  logic lu_unsigned,
	input  logic [63:0] lu_addr,
	input  logic [lsu_pkg::rd_w-1:0] lu_rd,
	// Store request
	input  logic su_valid,
	output logic su_ready,
	input  lsu_pkg::access_size_e su_size,
	input  logic [63:0] su_addr,
	input  logic [lsu_pkg::data_w-1:0] su_data,
	input  logic flush,
	// Load writeback
	output logic wb_valid,
	output logic [lsu_pkg::data_w-1:0] wb_data,
	output logic [lsu_pkg::rd_w-1:0] wb_rd
);

	// Even doublewords
	dtcm_bank_if #(.AW(AW)) bank_a ();
	// Odd doublewords
	dtcm_bank_if #(.AW(AW)) bank_b ();

	lsu #(
		.AW (AW)
	) lsu_inst (
		.CLK         (CLK),
		.reset       (reset),
		.lu_valid    (lu_valid),
		.lu_ready    (lu_ready),
		.lu_size     (lu_size),
		.lu_unsigned (lu_unsigned),
		.lu_addr     (lu_addr),
		.lu_rd       (lu_rd),
		.su_valid    (su_valid),
		.su_ready    (su_ready),
		.su_size     (su_size),
		.su_addr     (su_addr),
		.su_data     (su_data),
		.flush       (flush),
		.wb_valid    (wb_valid),
		.wb_data     (wb_data),
		.wb_rd       (wb_rd),
		.bank_a      (bank_a.unit),
		.bank_b      (bank_b.unit)
	);

	dtcm #(.AW(AW)) dtcm_a (
		.CLK   (CLK),
		.reset (reset),
		.bank  (bank_a.mem)
	);

	dtcm #(.AW(AW)) dtcm_b (
		.CLK   (CLK),
		.reset (reset),
		.bank  (bank_b.mem)
	);

endmodule

// ==== lsu_sva.sv ====
`timescale 1ns/10ps

module lsu_sva (
	input logic CLK,
	input logic reset,
	input logic lu_valid,
	input logic lu_ready,
	input logic flush,
	input logic wen_a,
	input logic wen_b,
	input logic wb_valid
);

	// Writeback quiet in the cycle after reset
	wb_after_reset: assert property (@(posedge CLK) reset |=> !wb_valid)
		else $error("wb_valid high in the cycle after reset");

	// Loads own the banks, so no write beside a valid load
	no_write_under_load: assert property (
		@(posedge CLK) disable iff (reset) lu_valid |-> !(wen_a || wen_b))
		else $error("bank write enable high while a load is valid");

	// Strobe needs a load taken two edges back, unflushed at both edges
	wb_has_source: assert property (
		@(posedge CLK) disable iff (reset)
		wb_valid |-> $past(lu_valid && lu_ready && !flush, 2) && !$past(flush))
		else $error("wb_valid without an unflushed load two edges earlier");

endmodule

bind lsu lsu_sva lsu_sva_inst (
	.CLK      (CLK),
	.reset    (reset),
	.lu_valid (lu_valid),
	.lu_ready (lu_ready),
	.flush    (flush),
	.wen_a    (bank_a.wen),
	.wen_b    (bank_b.wen),
	.wb_valid (wb_valid)
);

// ==== tb_lsu_top.sv ====
`timescale 1ns/10ps

module tb_lsu_top;

	localparam int AW = 4;
	// Two banks of 2**AW doublewords
	localparam int mem_bytes = 256;
	localparam int wait_limit = 10;

	logic CLK;
	logic reset;
	logic lu_valid;
	logic lu_ready;
	lsu_pkg::access_size_e lu_size;
	logic lu_unsigned;
	logic [63:0] lu_addr;
	logic [lsu_pkg::rd_w-1:0] lu_rd;
	logic su_valid;
	logic su_ready;
	lsu_pkg::access_size_e su_size;
	logic [63:0] su_addr;
	logic [lsu_pkg::data_w-1:0] su_data;
	logic flush;
	logic wb_valid;
	logic [lsu_pkg::data_w-1:0] wb_data;
	logic [lsu_pkg::rd_w-1:0] wb_rd;

	integer seed;
	// Number of the rising edge the current inputs are aimed at
	int edge_num;
	logic store_accepted;
	logic [31:0] r;
	logic [63:0] last_addr;

	// Reference byte image of both banks
	logic [7:0] model_mem [0:mem_bytes-1];
	// Loads in flight, oldest first
	logic [63:0] exp_data [$];
	logic [lsu_pkg::rd_w-1:0] exp_rd [$];
	int exp_edge [$];
	logic exp_flushed [$];

	lsu_top #(.AW(AW)) lsu_top_inst (
		.CLK         (CLK),
		.reset       (reset),
		.lu_valid    (lu_valid),
		.lu_ready    (lu_ready),
		.lu_size     (lu_size),
		.lu_unsigned (lu_unsigned),
		.lu_addr     (lu_addr),
		.lu_rd       (lu_rd),
		.su_valid    (su_valid),
		.su_ready    (su_ready),
		.su_size     (su_size),
		.su_addr     (su_addr),
		.su_data     (su_data),
		.flush       (flush),
		.wb_valid    (wb_valid),
		.wb_data     (wb_data),
		.wb_rd       (wb_rd)
	);

	always #5 CLK = ~CLK;

	function automatic logic [31:0] next_random();
		logic [31:0] v;
		v = $random(seed);
		return v;
	endfunction

	function automatic int bytes_of(input logic [1:0] size);
		case (size)
			2'd0: return 1;
			2'd1: return 2;
			2'd2: return 4;
			default: return 8;
		endcase
	endfunction

	// Little endian gather with wrap at the top of memory
	function automatic logic [63:0] model_load(input logic [63:0] addr, input logic [1:0] size,
			input logic uns);
		logic [63:0] raw;
		logic [7:0] idx;
		logic sign;
		int n;
		raw = '0;
		n = bytes_of(size);
		for (int b = 0; b < n; b++) begin
			idx = addr[7:0] + b[7:0];
			raw[8*b +: 8] = model_mem[idx];
		end
		sign = raw[8*n-1];
		// Fill above the access with the sign or with zeros
		for (int i = 8*n; i < 64; i++) begin
			raw[i] = uns ? 1'b0 : sign;
		end
		return raw;
	endfunction

	task automatic model_store(input logic [63:0] addr, input logic [1:0] size,
			input logic [63:0] data);
		logic [7:0] idx;
		for (int b = 0; b < bytes_of(size); b++) begin
			idx = addr[7:0] + b[7:0];
			model_mem[idx] = data[8*b +: 8];
		end
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
			$display("Done: errors found");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("[ERROR] %0t timed out: %s", $time, what);
		$display("Done: errors found");
		$fatal(1, "timeout");
	endtask

	task automatic drive_load(input logic [63:0] addr);
		logic [31:0] v;
		v = next_random();
		lu_valid = 1'b1;
		lu_size = lsu_pkg::access_size_e'(v[1:0]);
		lu_unsigned = v[2];
		lu_rd = v[3 +: lsu_pkg::rd_w];
		lu_addr = addr;
	endtask

	task automatic drive_store(input logic [63:0] addr);
		logic [31:0] v;
		v = next_random();
		su_valid = 1'b1;
		su_size = lsu_pkg::access_size_e'(v[1:0]);
		su_addr = addr;
		su_data = {next_random(), next_random()};
	endtask

	// Model the coming edge and check outputs mid cycle
	// Returns 1 ns after the edge
	task automatic step_cycle();
		edge_num++;
		store_accepted = su_valid && !lu_valid;
		if (lu_valid) begin
			exp_data.push_back(model_load(lu_addr, lu_size, lu_unsigned));
			exp_rd.push_back(lu_rd);
			exp_edge.push_back(edge_num);
			exp_flushed.push_back(1'b0);
		end else if (su_valid) begin
			model_store(su_addr, su_size, su_data);
		end
		// Flush cancels loads taken at this edge and the one before
		if (flush) begin
			for (int i = 0; i < exp_edge.size(); i++) begin
				if (exp_edge[i] >= edge_num - 1)
					exp_flushed[i] = 1'b1;
			end
		end
		@(negedge CLK);
		check_value("lu_ready", 64'(lu_ready), 64'd1);
		check_value("su_ready", 64'(su_ready), 64'(!lu_valid));
		// Outputs now belong to the load taken two edges ahead of the next one
		if (exp_edge.size() > 0 && exp_edge[0] == edge_num - 2) begin
			check_value("wb_valid", 64'(wb_valid), 64'(!exp_flushed[0]));
			if (!exp_flushed[0]) begin
				check_value("wb_data", wb_data, exp_data[0]);
				check_value("wb_rd", 64'(wb_rd), 64'(exp_rd[0]));
			end
			void'(exp_data.pop_front());
			void'(exp_rd.pop_front());
			void'(exp_edge.pop_front());
			void'(exp_flushed.pop_front());
		end else begin
			check_value("wb_valid", 64'(wb_valid), 64'd0);
		end
		@(posedge CLK);
		#1;
	endtask

	task automatic drain_loads();
		int spins;
		spins = 0;
		lu_valid = 1'b0;
		flush = 1'b0;
		while (exp_edge.size() > 0) begin
			if (spins >= wait_limit) begin
				report_timeout("writeback queue did not drain");
			end else begin
				step_cycle();
				spins++;
			end
		end
	endtask

	task automatic wait_store_taken();
		int spins;
		spins = 0;
		store_accepted = 1'b0;
		// Nothing to wait for once the store has gone
		while (su_valid && !store_accepted) begin
			if (spins >= wait_limit) begin
				report_timeout("held store never accepted");
			end else begin
				step_cycle();
				spins++;
			end
		end
		su_valid = 1'b0;
	endtask

	initial begin
		seed = 32'h0412ee22;
		edge_num = 1;
		CLK = 1'b0;
		reset = 1'b1;
		lu_valid = 1'b0;
		lu_size = lsu_pkg::size_byte;
		lu_unsigned = 1'b0;
		lu_addr = '0;
		lu_rd = '0;
		su_valid = 1'b0;
		su_size = lsu_pkg::size_byte;
		su_addr = '0;
		su_data = '0;
		flush = 1'b0;
		for (int i = 0; i < mem_bytes; i++) begin
			r = next_random();
			model_mem[i[7:0]] = r[7:0];
		end
		@(posedge CLK);
		#1;
		// Strobe stays low through the rest of reset
		repeat (4) step_cycle();
		reset = 1'b0;

		// Fill from the model with aligned doubles
		for (int i = 0; i < 32; i++) begin
			su_valid = 1'b1;
			su_size = lsu_pkg::size_double;
			su_addr = 64'(i) << 3;
			su_data = model_load(su_addr, lsu_pkg::size_double, 1'b1);
			step_cycle();
		end
		su_valid = 1'b0;

		// Random loads on full 64-bit addresses that alias onto 256 bytes
		for (int i = 0; i < 200; i++) begin
			r = next_random();
			lu_valid = 1'b0;
			if (r[1:0] != 2'd0)
				drive_load({next_random(), next_random()});
			step_cycle();
		end
		drain_loads();

		// Mixed stores and loads with each store pending until taken
		last_addr = '0;
		for (int i = 0; i < 300; i++) begin
			r = next_random();
			if (!su_valid && r[0]) begin
				last_addr = {next_random(), next_random()};
				drive_store(last_addr);
			end
			lu_valid = 1'b0;
			// Half of the loads land near the last store
			if (r[1])
				drive_load(r[2] ? {next_random(), next_random()} : last_addr + 64'(r[5:3]) - 64'd4);
			flush = (r[9:6] == 4'd0);
			step_cycle();
			if (store_accepted)
				su_valid = 1'b0;
		end
		flush = 1'b0;
		lu_valid = 1'b0;
		wait_store_taken();
		drain_loads();

		// Loads at the held store's address read the old bytes
		last_addr = {next_random(), next_random()};
		drive_store(last_addr);
		drive_load(last_addr);
		repeat (3) step_cycle();
		lu_valid = 1'b0;
		wait_store_taken();
		drive_load(last_addr);
		step_cycle();
		drain_loads();

		// Flush at the accept edge and one edge later
		drive_load({next_random(), next_random()});
		step_cycle();
		lu_valid = 1'b0;
		flush = 1'b1;
		step_cycle();
		drain_loads();
		for (int i = 0; i < 40; i++) begin
			r = next_random();
			drive_load({next_random(), next_random()});
			flush = (r[2:0] == 3'd0);
			step_cycle();
		end
		drain_loads();

		// Back-to-back loads give a strobe every cycle
		for (int i = 0; i < 16; i++) begin
			drive_load({next_random(), next_random()});
			step_cycle();
		end
		drain_loads();

		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== lsu_top.f ====
lsu_pkg.sv
dtcm_bank_if.sv
dtcm.sv
store_align.sv
load_align.sv
lsu.sv
lsu_top.sv
lsu_sva.sv
tb_lsu_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        = tb_lsu_top
FILELIST   = lsu_top.f
BUILD_DIR  = obj_dir
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/10ps

SOURCES = $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
